// ==== Makefile ====
SIM       := verilator
TOP       := tb_irq_controller
FILELIST  := vlog.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/irq_ctrl_if.sv ====
// Register block to sequencer link
`timescale 1ns/1ps

interface irq_ctrl_if import irq_pkg::*; ();

    // status from the register block
    irq_vec_t     pending;
    irq_vec_t     active;
    stack_entry_t stack_top;

    // control from the sequencer
    irq_cmd_e     cmd;
    device_id_t   device_id;   // device in request or service
    prio_level_t  cur_level;

    modport regs (
        output pending,
        output active,
        output stack_top,
        input  cmd,
        input  device_id,
        input  cur_level
    );

    modport seq (
        input  active,
        input  stack_top,
        output cmd,
        output device_id,
        output cur_level
    );

endinterface

// ==== common/irq_pkg.sv ====
// Interrupt controller shared definitions
package irq_pkg;

    localparam int NUM_IRQ    = 32;  // fixed by the 32-bit csr data width
    localparam int NUM_LEVELS = 4;   // level 0 is the highest

    typedef logic [NUM_IRQ-1:0]            irq_vec_t;
    typedef logic [$clog2(NUM_IRQ)-1:0]    device_id_t;
    typedef logic [$clog2(NUM_LEVELS)-1:0] prio_level_t;
    typedef logic [11:0]                   csr_addr_t;
    typedef logic [31:0]                   csr_data_t;

    // saved context with the device in the upper bits
    typedef struct packed {
        device_id_t  device_id;
        prio_level_t level;
    } stack_entry_t;

    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_enter = 2'd1,  // set active and push context
        cmd_exit  = 2'd2   // clear pending and active and pop context
    } irq_cmd_e;

    //////////////////////////////////////////////////
    // csr map
    //////////////////////////////////////////////////
    localparam csr_addr_t CSR_ENABLE  = 12'h7C0;
    localparam csr_addr_t CSR_PRIO0   = 12'h7C1;
    localparam csr_addr_t CSR_PRIO1   = 12'h7C2;
    localparam csr_addr_t CSR_PRIO2   = 12'h7C3;
    localparam csr_addr_t CSR_PRIO3   = 12'h7C4;
    localparam csr_addr_t CSR_PENDING = 12'h7C5;
    localparam csr_addr_t CSR_ACTIVE  = 12'h7C6;
    localparam csr_addr_t CSR_STACK   = 12'h7C7;

    //////////////////////////////////////////////////
    // reset values
    //////////////////////////////////////////////////
    localparam irq_vec_t ENABLE_RESET = '1;  // all sources enabled
    localparam irq_vec_t PRIO0_RESET  = 32'h3C;
    localparam irq_vec_t PRIO1_RESET  = 32'h2;
    localparam irq_vec_t PRIO2_RESET  = 32'h1;
    localparam irq_vec_t PRIO3_RESET  = 32'h0;

endpackage

// ==== irq_controller/irq_csr_regs.sv ====
// Interrupt status and control registers
`timescale 1ns/1ps

module irq_csr_regs import irq_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  irq_vec_t   irq_in,
    input  logic       csr_wr_en,
    input  csr_addr_t  csr_adr_wr,
    input  csr_data_t  csr_wrdata,
    input  csr_addr_t  csr_adr_rd,
    output csr_data_t  csr_rddata,
    output irq_vec_t   level_masks [NUM_LEVELS],
    irq_ctrl_if.regs   ctrl
);

    irq_vec_t     enable_reg;
    irq_vec_t     prio_reg [NUM_LEVELS];
    irq_vec_t     pending_reg;
    irq_vec_t     active_reg;
    stack_entry_t stack_reg;
    stack_entry_t cur_ctx;      // context now in service

    irq_vec_t     irq_sync;
    irq_vec_t     irq_dly;
    irq_vec_t     new_evt;
    irq_vec_t     dev_mask;

    logic         wr_enable;
    logic         wr_pending;
    logic         wr_active;
    logic         wr_stack;

    assign wr_enable  = csr_wr_en && (csr_adr_wr == CSR_ENABLE);
    assign wr_pending = csr_wr_en && (csr_adr_wr == CSR_PENDING);
    assign wr_active  = csr_wr_en && (csr_adr_wr == CSR_ACTIVE);
    assign wr_stack   = csr_wr_en && (csr_adr_wr == CSR_STACK);

    assign dev_mask = irq_vec_t'(1) << ctrl.device_id;

    //////////////////////////////////////////////////
    // rising edge detection
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_sync <= '0;
            irq_dly  <= '0;
        end else begin
            irq_sync <= irq_in & enable_reg;
            irq_dly  <= irq_sync;
        end
    end

    assign new_evt = irq_sync & ~irq_dly;  // one cycle per rising edge

    //////////////////////////////////////////////////
    // enable and priority masks
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_reg  <= ENABLE_RESET;
            prio_reg[0] <= PRIO0_RESET;
            prio_reg[1] <= PRIO1_RESET;
            prio_reg[2] <= PRIO2_RESET;
            prio_reg[3] <= PRIO3_RESET;
        end else begin
            if (wr_enable)
                enable_reg <= csr_wrdata;
            for (int i = 0; i < NUM_LEVELS; i++) begin
                if (csr_wr_en && (csr_adr_wr == CSR_PRIO0 + csr_addr_t'(i)))
                    prio_reg[i] <= csr_wrdata;
            end
        end
    end

    assign level_masks = prio_reg;

    //////////////////////////////////////////////////
    // pending and active vectors
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reg <= '0;
        end else if (ctrl.cmd == cmd_exit) begin
            pending_reg <= (pending_reg & ~dev_mask) | new_evt;
        end else if (wr_pending) begin
            pending_reg <= csr_wrdata | new_evt;
        end else begin
            pending_reg <= pending_reg | new_evt;  // events are never lost
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            active_reg <= '0;
        else if (ctrl.cmd == cmd_enter)
            active_reg <= active_reg | dev_mask;
        else if (ctrl.cmd == cmd_exit)
            active_reg <= active_reg & ~dev_mask;
        else if (wr_active)
            active_reg <= csr_wrdata;
    end

    // entry saves the interrupted context in the one-entry stack
    // and exit hands it back to the current slot
    always_ff @(posedge clk) begin
        if (reset) begin
            stack_reg <= '0;
            cur_ctx   <= '0;
        end else if (ctrl.cmd == cmd_enter) begin
            stack_reg <= cur_ctx;
            cur_ctx   <= {ctrl.device_id, ctrl.cur_level};
        end else if (ctrl.cmd == cmd_exit) begin
            stack_reg <= '0;
            cur_ctx   <= stack_reg;
        end else if (wr_stack) begin
            stack_reg <= stack_entry_t'(csr_wrdata[$bits(stack_entry_t)-1:0]);
        end
    end

    assign ctrl.pending   = pending_reg;
    assign ctrl.active    = active_reg;
    assign ctrl.stack_top = stack_reg;

    //////////////////////////////////////////////////
    // csr read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (csr_adr_rd)
            CSR_ENABLE:  csr_rddata = enable_reg;
            CSR_PRIO0:   csr_rddata = prio_reg[0];
            CSR_PRIO1:   csr_rddata = prio_reg[1];
            CSR_PRIO2:   csr_rddata = prio_reg[2];
            CSR_PRIO3:   csr_rddata = prio_reg[3];
            CSR_PENDING: csr_rddata = pending_reg;
            CSR_ACTIVE:  csr_rddata = active_reg;
            CSR_STACK:   csr_rddata = csr_data_t'(stack_reg);  // zero extended
            default:     csr_rddata = '0;
        endcase
    end

endmodule

// ==== irq_controller/irq_priority_resolver.sv ====
// Winning level and device selection
`timescale 1ns/1ps

module irq_priority_resolver import irq_pkg::*; (
    input  irq_vec_t    pending,
    input  irq_vec_t    active,
    input  irq_vec_t    level_masks [NUM_LEVELS],
    output logic        found,
    output prio_level_t best_level,
    output device_id_t  best_device
);

    irq_vec_t                cand;
    irq_vec_t                win_vec;
    logic [NUM_LEVELS-1:0]   level_hit;

    assign cand = pending & ~active;  // sources already in service drop out

    always_comb begin
        for (int l = 0; l < NUM_LEVELS; l++) begin
            level_hit[l] = |(level_masks[l] & cand);
        end
    end

    assign found = |level_hit;

    // scan from the bottom so the lowest hit wins
    always_comb begin
        best_level = '0;
        for (int l = NUM_LEVELS - 1; l >= 0; l--) begin
            if (level_hit[l])
                best_level = prio_level_t'(l);
        end
    end

    assign win_vec = level_masks[best_level] & cand;

    always_comb begin
        best_device = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (win_vec[i])
                best_device = device_id_t'(i);  // lowest index in level
        end
    end

endmodule

// ==== irq_controller/irq_sequencer.sv ====
// Request, service and return FSM
`timescale 1ns/1ps

module irq_sequencer import irq_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        irq_ack,
    input  logic        eret_ack,
    input  logic        found,
    input  prio_level_t best_level,
    input  device_id_t  best_device,
    output logic        proc_req,
    irq_ctrl_if.seq     ctrl
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_service,
        st_return
    } seq_state_e;

    seq_state_e  state;
    device_id_t  device_q;
    prio_level_t level_q;
    irq_cmd_e    cmd_d;
    logic        preempt;

    // only a strictly higher level (lower number) may interrupt
    assign preempt = found && (best_level < level_q);

    //////////////////////////////////////////////////
    // commands to the register block
    //////////////////////////////////////////////////
    always_comb begin
        cmd_d = cmd_none;
        if (state == st_request && irq_ack)
            cmd_d = cmd_enter;
        else if (state == st_service && eret_ack)
            cmd_d = cmd_exit;
    end

    //////////////////////////////////////////////////
    // state, request and current context
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            proc_req <= 1'b0;
            device_q <= '0;
            level_q  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (found) begin
                        state    <= st_request;
                        proc_req <= 1'b1;
                        device_q <= best_device;
                        level_q  <= best_level;
                    end
                end

                // device_q held until the core answers
                st_request: begin
                    if (irq_ack) begin
                        state    <= st_service;
                        proc_req <= 1'b0;
                    end
                end

                st_service: begin
                    if (eret_ack) begin
                        state    <= st_return;
                        device_q <= ctrl.stack_top.device_id;  // back to saved context
                        level_q  <= ctrl.stack_top.level;
                    end else if (preempt) begin
                        state    <= st_request;
                        proc_req <= 1'b1;
                        device_q <= best_device;
                        level_q  <= best_level;
                    end
                end

                st_return: begin
                    if (|ctrl.active)
                        state <= st_service;  // resume interrupted handler
                    else
                        state <= st_idle;
                end

                default: begin
                    state    <= st_idle;
                    proc_req <= 1'b0;
                end
            endcase
        end
    end

    assign ctrl.cmd       = cmd_d;
    assign ctrl.device_id = device_q;
    assign ctrl.cur_level = level_q;

endmodule

// ==== source/irq_controller_top.sv ====
// Interrupt controller top level
`timescale 1ns/1ps

module irq_controller_top import irq_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  irq_vec_t   irq_in,
    input  logic       irq_ack,
    input  logic       eret_ack,
    output logic       proc_req,
    output device_id_t device_id,
    input  logic       csr_wr_en,
    input  csr_addr_t  csr_adr_wr,
    input  csr_data_t  csr_wrdata,
    input  csr_addr_t  csr_adr_rd,
    output csr_data_t  csr_rddata
);

    irq_vec_t    level_masks [NUM_LEVELS];
    logic        found;
    prio_level_t best_level;
    device_id_t  best_device;

    irq_ctrl_if ctrl_bus ();

    irq_csr_regs i_irq_csr_regs (
        .clk         (clk),
        .reset       (reset),
        .irq_in      (irq_in),
        .csr_wr_en   (csr_wr_en),
        .csr_adr_wr  (csr_adr_wr),
        .csr_wrdata  (csr_wrdata),
        .csr_adr_rd  (csr_adr_rd),
        .csr_rddata  (csr_rddata),
        .level_masks (level_masks),
        .ctrl        (ctrl_bus)
    );

    irq_priority_resolver i_irq_priority_resolver (
        .pending     (ctrl_bus.pending),
        .active      (ctrl_bus.active),
        .level_masks (level_masks),
        .found       (found),
        .best_level  (best_level),
        .best_device (best_device)
    );

    irq_sequencer i_irq_sequencer (
        .clk         (clk),
        .reset       (reset),
        .irq_ack     (irq_ack),
        .eret_ack    (eret_ack),
        .found       (found),
        .best_level  (best_level),
        .best_device (best_device),
        .proc_req    (proc_req),
        .ctrl        (ctrl_bus)
    );

    assign device_id = ctrl_bus.device_id;  // handler select to fetch

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 10;  // 20 ns period

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

// ==== testbench/tb_irq_controller.sv ====
// Interrupt controller directed tests
`timescale 1ns/1ps

module tb_irq_controller import irq_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int REQ_TIMEOUT  = 20;
    localparam int BUDGET_TOTAL = 50 + 100 + 300 + 150 + 900 + 500;  // per test budgets
    localparam int unsigned RAND_SEED = 32'hea8b_da40;

    logic       clk;
    logic       reset;
    irq_vec_t   irq_in;
    logic       irq_ack;
    logic       eret_ack;
    logic       proc_req;
    device_id_t device_id;
    logic       csr_wr_en;
    csr_addr_t  csr_adr_wr;
    csr_data_t  csr_wrdata;
    csr_addr_t  csr_adr_rd;
    csr_data_t  csr_rddata;

    irq_vec_t    model_masks [NUM_LEVELS];  // level masks as software set them
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen i_tb_clock_gen (.clk(clk));

    irq_controller_top i_irq_controller_top (
        .clk        (clk),
        .reset      (reset),
        .irq_in     (irq_in),
        .irq_ack    (irq_ack),
        .eret_ack   (eret_ack),
        .proc_req   (proc_req),
        .device_id  (device_id),
        .csr_wr_en  (csr_wr_en),
        .csr_adr_wr (csr_adr_wr),
        .csr_wrdata (csr_wrdata),
        .csr_adr_rd (csr_adr_rd),
        .csr_rddata (csr_rddata)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic compare_csr(string what, csr_data_t got, csr_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_device(string what, device_id_t got, device_id_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // bus and core helpers
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #2;  // drive point
    endtask

    task automatic write_csr(csr_addr_t addr, csr_data_t data);
        csr_wr_en  = 1'b1;
        csr_adr_wr = addr;
        csr_wrdata = data;
        next_cycle();
        csr_wr_en  = 1'b0;
    endtask

    task automatic check_csr(csr_addr_t addr, csr_data_t exp, string what);
        csr_adr_rd = addr;
        #1;  // combinational read settles
        compare_csr(what, csr_rddata, exp);
    endtask

    task automatic set_levels(irq_vec_t p0, irq_vec_t p1, irq_vec_t p2, irq_vec_t p3);
        model_masks[0] = p0;
        model_masks[1] = p1;
        model_masks[2] = p2;
        model_masks[3] = p3;
        for (int l = 0; l < NUM_LEVELS; l++) begin
            write_csr(CSR_PRIO0 + csr_addr_t'(l), model_masks[l]);
        end
    endtask

    task automatic wait_req(output logic ok);
        int n;
        n = 0;
        while (!proc_req && n < REQ_TIMEOUT) begin
            next_cycle();
            n++;
        end
        ok = proc_req;
        if (!ok) begin
            $display("proc_req did not rise within %0d cycles at %0t ns", REQ_TIMEOUT, $time);
            errors++;
        end
    endtask

    task automatic ack_irq();
        irq_ack = 1'b1;
        next_cycle();
        irq_ack = 1'b0;
    endtask

    // eret pulse and one cycle through the return state
    task automatic return_irq();
        eret_ack = 1'b1;
        next_cycle();
        eret_ack = 1'b0;
        next_cycle();
    endtask

    // winner is the lowest index in the lowest level with a candidate
    function automatic int model_winner(irq_vec_t cand);
        for (int l = 0; l < NUM_LEVELS; l++) begin
            for (int i = 0; i < NUM_IRQ; i++) begin
                if (model_masks[l][i] && cand[i])
                    return i;
            end
        end
        return -1;
    endfunction

    task automatic finish_test(string name, int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_reset_values();
        int err_start;
        err_start = errors;
        check_csr(CSR_ENABLE, ENABLE_RESET, "enable");
        check_csr(CSR_PRIO0, PRIO0_RESET, "prio0");
        check_csr(CSR_PRIO1, PRIO1_RESET, "prio1");
        check_csr(CSR_PRIO2, PRIO2_RESET, "prio2");
        check_csr(CSR_PRIO3, PRIO3_RESET, "prio3");
        check_csr(CSR_PENDING, '0, "pending");
        check_csr(CSR_ACTIVE, '0, "active");
        check_csr(CSR_STACK, '0, "stack");
        check_csr(12'h000, '0, "unmapped 000");
        check_csr(12'h7C8, '0, "unmapped 7c8");
        compare_bit("proc_req", proc_req, 1'b0);
        compare_device("device_id", device_id, '0);
        finish_test("reset_values", err_start);
    endtask

    task automatic test_csr_access();
        int        err_start;
        csr_data_t vals [5];
        csr_data_t stack_val;
        err_start = errors;
        for (int i = 0; i < 5; i++) begin  // enable and prio0 to prio3 in address order
            vals[i] = $urandom;
            write_csr(CSR_ENABLE + csr_addr_t'(i), vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            check_csr(CSR_ENABLE + csr_addr_t'(i), vals[i], "mask readback");
        end
        stack_val = $urandom;
        write_csr(CSR_STACK, stack_val);
        check_csr(CSR_STACK, stack_val & 32'h7F, "stack readback");  // 7-bit entry
        write_csr(CSR_STACK, '0);
        write_csr(CSR_ENABLE, '1);
        finish_test("csr_access", err_start);
    endtask

    task automatic test_single_irq();
        int       err_start;
        int       src;
        irq_vec_t src_bit;
        err_start = errors;
        set_levels(32'h0000_00FF, 32'h0000_FF00, 32'h00FF_0000, 32'hFF00_0000);
        src     = $urandom_range(31, 0);
        src_bit = irq_vec_t'(1) << src;
        irq_in  = src_bit;
        next_cycle();
        next_cycle();
        check_csr(CSR_PENDING, src_bit, "pending after event");
        compare_bit("proc_req before latency", proc_req, 1'b0);
        next_cycle();
        compare_bit("proc_req after two edges", proc_req, 1'b1);
        compare_device("requested device", device_id, device_id_t'(src));
        ack_irq();
        check_csr(CSR_PENDING, src_bit, "pending in service");
        check_csr(CSR_ACTIVE, src_bit, "active in service");
        return_irq();
        check_csr(CSR_PENDING, '0, "pending after return");
        check_csr(CSR_ACTIVE, '0, "active after return");
        repeat (10) next_cycle();  // input still held high
        compare_bit("proc_req with held input", proc_req, 1'b0);
        check_csr(CSR_PENDING, '0, "pending with held input");
        irq_in = '0;
        next_cycle();
        next_cycle();
        finish_test("single_irq", err_start);
    endtask

    task automatic test_disabled_source();
        int        err_start;
        int        src;
        csr_data_t enable_val;
        err_start  = errors;
        src        = $urandom_range(31, 0);
        enable_val = $urandom & ~(csr_data_t'(1) << src);
        write_csr(CSR_ENABLE, enable_val);
        check_csr(CSR_ENABLE, enable_val, "enable mask");
        irq_in = irq_vec_t'(1) << src;
        repeat (8) next_cycle();
        check_csr(CSR_PENDING, '0, "pending of masked source");
        compare_bit("proc_req of masked source", proc_req, 1'b0);
        irq_in = '0;
        next_cycle();
        next_cycle();  // input low before the mask opens again
        write_csr(CSR_ENABLE, '1);
        finish_test("disabled_source", err_start);
    endtask

    task automatic test_simultaneous();
        int       err_start;
        int       guard;
        int       win;
        logic     ok;
        irq_vec_t remaining;
        err_start = errors;
        // level order runs against index order
        set_levels(32'hFF00_0000, 32'h00FF_0000, 32'h0000_FF00, 32'h0000_00FF);
        remaining = '0;
        repeat (4) remaining = remaining | (irq_vec_t'(1) << $urandom_range(31, 0));
        irq_in = remaining;
        guard  = 0;
        while (remaining != '0 && guard < NUM_IRQ) begin
            guard++;
            wait_req(ok);
            if (!ok)
                break;
            win = model_winner(remaining);
            if (win < 0)
                break;
            compare_device("winner in order", device_id, device_id_t'(win));
            ack_irq();
            return_irq();
            remaining[win] = 1'b0;
        end
        check_csr(CSR_PENDING, '0, "pending after all served");
        check_csr(CSR_ACTIVE, '0, "active after all served");
        compare_bit("proc_req after all served", proc_req, 1'b0);
        irq_in = '0;
        next_cycle();
        next_cycle();
        finish_test("simultaneous", err_start);
    endtask

    task automatic test_preemption();
        int       err_start;
        int       low_src;
        int       high_src;
        irq_vec_t low_bit;
        irq_vec_t high_bit;
        logic     ok;
        err_start = errors;
        low_src   = $urandom_range(31, 1);
        high_src  = (low_src + int'($urandom_range(30, 1))) % NUM_IRQ;
        low_bit   = irq_vec_t'(1) << low_src;
        high_bit  = irq_vec_t'(1) << high_src;
        set_levels(high_bit, '0, low_bit, '0);
        irq_in = low_bit;
        wait_req(ok);
        compare_device("level 2 device", device_id, device_id_t'(low_src));
        ack_irq();
        check_csr(CSR_ACTIVE, low_bit, "active before preemption");
        irq_in = low_bit | high_bit;
        wait_req(ok);
        compare_device("preempting device", device_id, device_id_t'(high_src));
        ack_irq();
        check_csr(CSR_ACTIVE, low_bit | high_bit, "active while nested");
        check_csr(CSR_STACK, csr_data_t'({device_id_t'(low_src), prio_level_t'(2)}),
                  "saved context");
        return_irq();
        compare_device("resumed device", device_id, device_id_t'(low_src));
        check_csr(CSR_ACTIVE, low_bit, "active after first return");
        compare_bit("proc_req after first return", proc_req, 1'b0);
        return_irq();
        check_csr(CSR_ACTIVE, '0, "active after second return");
        compare_bit("proc_req after second return", proc_req, 1'b0);
        irq_in = '0;
        next_cycle();
        finish_test("preemption", err_start);
    endtask

    //////////////////////////////////////////////////
    // watchdog and main sequence
    //////////////////////////////////////////////////
    initial begin
        repeat (RESET_CYCLES + BUDGET_TOTAL) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish",
                 RESET_CYCLES + BUDGET_TOTAL);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        irq_in       = '0;
        irq_ack      = 1'b0;
        eret_ack     = 1'b0;
        csr_wr_en    = 1'b0;
        csr_adr_wr   = '0;
        csr_wrdata   = '0;
        csr_adr_rd   = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_values();
        test_csr_access();
        test_single_irq();
        test_disabled_source();
        test_simultaneous();
        test_preemption();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/irq_pkg.sv
common/irq_ctrl_if.sv
irq_controller/irq_csr_regs.sv
irq_controller/irq_priority_resolver.sv
irq_controller/irq_sequencer.sv
source/irq_controller_top.sv
testbench/tb_clock_gen.sv
testbench/tb_irq_controller.sv
